//--- Makefile
# Verilator simulation of the bilinear blend array

TOP = tb_tmu_blend_array
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

obj_dir/V$(TOP): files.f $(wildcard hw/*.sv hw/*.svh verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f files.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
+incdir+hw
hw/tmu_pix_pkg.sv
hw/tmu_frag_pkg.sv
hw/tmu_frag_dispatch.sv
hw/tmu_blend.sv
hw/tmu_frag_merge.sv
hw/tmu_blend_array.sv
verif/tb_tmu_blend_array.sv

//--- hw/tmu_blend.sv
/*
 * Bilinear blend lane, five register stages on one shared enable
 *  - stage 1 forms the four weights from the fractions
 *  - stage 2 retimes the weights ahead of the multipliers
 *  - stage 3 multiplies each weight with each texel channel
 *  - stage 4 retimes the products
 *  - stage 5 sums per channel, address travels alongside
 */
module tmu_blend (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	input  logic                     pipe_stb_i,
	input  tmu_frag_pkg::frag_t      frag_i,
	output logic                     pipe_ack_o,

	output logic                     pipe_stb_o,
	output tmu_frag_pkg::blend_res_t res_o,
	input  logic                     pipe_ack_i,

	output logic                     busy_o
);

	// Per-channel product or sum
	// Weights sum to 4096, so 12 fraction bits plus the channel width suffice
	typedef struct packed {
		logic [16:0] r;
		logic [17:0] g;
		logic [16:0] b;
	} chan_acc_t;

	logic pipe_en; // Single enable, keeps hard multipliers in one clock domain

	logic [5:1] valid; // Occupancy of stages 1..5
	tmu_frag_pkg::dadr_t [5:1] dadr; // Address delay line

	logic [6:0] x_inv; // 64 - x_frac
	logic [6:0] y_inv; // 64 - y_frac

	logic [3:0][12:0] w_1; // Weights, index 0..3 follows texels a..d
	logic [3:0][12:0] w_2;
	tmu_pix_pkg::texel_quad_t tex_1;
	tmu_pix_pkg::texel_quad_t tex_2;
	tmu_pix_pkg::rgb565_t [3:0] tex_arr_2; // Texels indexed like the weights

	chan_acc_t [3:0] prod_3; // Weighted channels, one entry per texel
	chan_acc_t [3:0] prod_4;
	chan_acc_t sum_5;        // Full precision result

	assign x_inv = 7'd64 - {1'b0, frag_i.frac.x_frac};
	assign y_inv = 7'd64 - {1'b0, frag_i.frac.y_frac};

	assign tex_arr_2 = {tex_2.d, tex_2.c, tex_2.b, tex_2.a};

	// Control, only the valid bits are reset
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid <= '0;
		end else if (pipe_en) begin
			valid <= {valid[4:1], pipe_stb_i}; // Advance one stage
		end
	end

	// Datapath
	always_ff @(posedge sys_clk) begin
		if (pipe_en) begin
			dadr <= {dadr[4:1], frag_i.dadr};

			// Stage 1
			w_1[0] <= x_inv * y_inv;                                 // pa
			w_1[1] <= {1'b0, frag_i.frac.x_frac} * y_inv;            // pb
			w_1[2] <= x_inv * {1'b0, frag_i.frac.y_frac};            // pc
			w_1[3] <= frag_i.frac.x_frac * frag_i.frac.y_frac;       // pd
			tex_1 <= frag_i.texels;

			// Stage 2
			w_2 <= w_1;
			tex_2 <= tex_1;

			// Stage 3, twelve multipliers
			for (int k = 0; k < 4; k++) begin
				prod_3[k].r <= w_2[k] * tex_arr_2[k].r;
				prod_3[k].g <= w_2[k] * tex_arr_2[k].g;
				prod_3[k].b <= w_2[k] * tex_arr_2[k].b;
			end

			// Stage 4
			prod_4 <= prod_3;

			// Stage 5, cannot overflow as the weights sum to 4096
			sum_5.r <= prod_4[0].r + prod_4[1].r + prod_4[2].r + prod_4[3].r;
			sum_5.g <= prod_4[0].g + prod_4[1].g + prod_4[2].g + prod_4[3].g;
			sum_5.b <= prod_4[0].b + prod_4[1].b + prod_4[2].b + prod_4[3].b;
		end
	end

	// Whole lane moves when the last stage is free or being drained
	assign pipe_en = ~valid[5] | pipe_ack_i;
	assign pipe_ack_o = pipe_en;

	assign pipe_stb_o = valid[5];

	// Drop the 12 fraction bits to get back to RGB565
	assign res_o = '{
		dadr:  dadr[5],
		color: '{r: sum_5.r[16:12], g: sum_5.g[17:12], b: sum_5.b[16:12]}
	};

	assign busy_o = |valid;

	// A stalled result must stay put until the merger takes it
	a_hold_stalled: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o && $stable(res_o));

endmodule

//--- hw/tmu_blend_array.sv
/*
 * Bilinear blend array, top level
 *  - dispatcher dealing fragments round-robin
 *  - TMU_LANES identical five-stage blend lanes
 *  - merger restoring arrival order
 */
`include "tmu_cfg.svh"

module tmu_blend_array (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	input  logic                     pipe_stb_i,
	input  tmu_frag_pkg::frag_t      frag_i,
	output logic                     pipe_ack_o,

	output logic                     pipe_stb_o,
	output tmu_frag_pkg::blend_res_t res_o,
	input  logic                     pipe_ack_i,

	output logic                     busy_o
);

	logic [`TMU_LANES-1:0] lane_stb;  // Dispatcher to lanes
	logic [`TMU_LANES-1:0] lane_ack;
	tmu_frag_pkg::frag_t   lane_frag; // Broadcast fragment bus

	logic [`TMU_LANES-1:0] res_stb;   // Lanes to merger
	logic [`TMU_LANES-1:0] res_ack;
	tmu_frag_pkg::blend_res_t [`TMU_LANES-1:0] res;

	logic [`TMU_LANES-1:0] lane_busy;

	tmu_frag_dispatch dispatch (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.pipe_stb_i  (pipe_stb_i),
		.frag_i      (frag_i),
		.pipe_ack_o  (pipe_ack_o),
		.lane_stb_o  (lane_stb),
		.lane_frag_o (lane_frag),
		.lane_ack_i  (lane_ack)
	);

	for (genvar i = 0; i < `TMU_LANES; i++) begin : g_lane
		tmu_blend lane (
			.sys_clk    (sys_clk),
			.sys_rst    (sys_rst),
			.pipe_stb_i (lane_stb[i]),
			.frag_i     (lane_frag),
			.pipe_ack_o (lane_ack[i]),
			.pipe_stb_o (res_stb[i]),
			.res_o      (res[i]),
			.pipe_ack_i (res_ack[i]),
			.busy_o     (lane_busy[i])
		);
	end

	tmu_frag_merge merge (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.res_stb_i  (res_stb),
		.res_i      (res),
		.res_ack_o  (res_ack),
		.pipe_stb_o (pipe_stb_o),
		.res_o      (res_o),
		.pipe_ack_i (pipe_ack_i)
	);

	assign busy_o = |lane_busy; // Any lane still holding a fragment

endmodule

//--- hw/tmu_cfg.svh
/*
 * Build-time configuration of the texture blend array
 *  - framebuffer byte address width
 *  - number of parallel blend lanes
 */
`ifndef TMU_CFG_SVH
`define TMU_CFG_SVH

// Framebuffer byte address width
// Fragments carry a 16-bit word address, one bit narrower
`define TMU_FML_DEPTH 26

// Number of blend lanes behind the dispatcher
// 2, 4 and 8 are the supported sizes
`define TMU_LANES 4

`endif

//--- hw/tmu_frag_dispatch.sv
/*
 * Fragment dispatcher
 *  - round-robin pointer over the blend lanes
 *  - strobe steered to the pointed lane only
 *  - fragment bus broadcast to all lanes
 *  - upstream acknowledge taken from the pointed lane
 */
`include "tmu_cfg.svh"

module tmu_frag_dispatch (
	input  logic                   sys_clk,
	input  logic                   sys_rst,

	input  logic                   pipe_stb_i,
	input  tmu_frag_pkg::frag_t    frag_i,
	output logic                   pipe_ack_o,

	output logic [`TMU_LANES-1:0]  lane_stb_o,
	output tmu_frag_pkg::frag_t    lane_frag_o,
	input  logic [`TMU_LANES-1:0]  lane_ack_i
);

	localparam int PTR_W = (`TMU_LANES > 1) ? $clog2(`TMU_LANES) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`TMU_LANES - 1);

	logic [PTR_W-1:0] ptr; // Lane receiving the next fragment
	logic xfer;            // Fragment handed to a lane this cycle

	// Every lane sees the same data, only the strobe picks the receiver
	assign lane_frag_o = frag_i;

	always_comb begin
		for (int i = 0; i < `TMU_LANES; i++) begin
			lane_stb_o[i] = pipe_stb_i && (ptr == PTR_W'(i)); // One-hot or idle
		end
	end

	// Back-pressure comes straight from the selected lane
	assign pipe_ack_o = lane_ack_i[ptr];
	assign xfer = pipe_stb_i & pipe_ack_o;

	// Step to the next lane once the current one has taken its fragment
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ptr <= '0; // Merger starts at lane 0 too
		end else if (xfer) begin
			if (ptr == PTR_LAST)
				ptr <= '0; // Wrap around
			else
				ptr <= ptr + 1'b1;
		end
	end

	// Pointer must never select a lane that does not exist
	a_ptr_in_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
		xfer |=> ptr < `TMU_LANES);

endmodule

//--- hw/tmu_frag_merge.sv
/*
 * Result merger
 *  - round-robin pointer in the same order as the dispatcher
 *  - output multiplexed from the pointed lane
 *  - acknowledge routed back to the pointed lane only
 */
`include "tmu_cfg.svh"

module tmu_frag_merge (
	input  logic                                     sys_clk,
	input  logic                                     sys_rst,

	input  logic [`TMU_LANES-1:0]                    res_stb_i,
	input  tmu_frag_pkg::blend_res_t [`TMU_LANES-1:0] res_i,
	output logic [`TMU_LANES-1:0]                    res_ack_o,

	output logic                                     pipe_stb_o,
	output tmu_frag_pkg::blend_res_t                 res_o,
	input  logic                                     pipe_ack_i
);

	localparam int PTR_W = (`TMU_LANES > 1) ? $clog2(`TMU_LANES) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`TMU_LANES - 1);

	logic [PTR_W-1:0] ptr; // Lane holding the oldest outstanding result
	logic xfer;            // Result leaves this cycle

	// Present only the lane whose turn it is
	assign pipe_stb_o = res_stb_i[ptr];
	assign res_o = res_i[ptr];
	assign xfer = pipe_stb_o & pipe_ack_i;

	// Other lanes see acknowledge low and hold their last stage
	always_comb begin
		for (int i = 0; i < `TMU_LANES; i++) begin
			res_ack_o[i] = pipe_ack_i && (ptr == PTR_W'(i));
		end
	end

	// Advance after each result, same rotation as dispatch
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ptr <= '0;
		end else if (xfer) begin
			if (ptr == PTR_LAST)
				ptr <= '0;
			else
				ptr <= ptr + 1'b1;
		end
	end

	// Any lane-side transfer must be the selected lane strobing out
	a_xfer_selected: assert property (@(posedge sys_clk) disable iff (sys_rst)
		|(res_stb_i & res_ack_o) |-> xfer && res_stb_i[ptr]
			&& $onehot(res_stb_i & res_ack_o));

endmodule

//--- hw/tmu_frag_pkg.sv
/*
 * Pipeline transport types
 *  - dadr_t       destination framebuffer word address
 *  - frag_t       fragment entering the blend array
 *  - blend_res_t  blended colour leaving the blend array
 */
`include "tmu_cfg.svh"

package tmu_frag_pkg;

	// Word address, one bit narrower than the byte address
	typedef logic [`TMU_FML_DEPTH-2:0] dadr_t;

	// One fragment as handed over by the texel fetch
	typedef struct packed {
		dadr_t                    dadr;   // Passed through untouched
		tmu_pix_pkg::texel_quad_t texels; // 2x2 neighbourhood
		tmu_pix_pkg::frac_t       frac;   // Sample position inside the quad
	} frag_t;

	// Blended pixel on its way to the framebuffer writer
	typedef struct packed {
		dadr_t                dadr;  // Same word as in the fragment
		tmu_pix_pkg::rgb565_t color; // Truncated weighted sum
	} blend_res_t;

endpackage

//--- hw/tmu_pix_pkg.sv
/*
 * Pixel format types
 *  - rgb565_t      one 16-bit colour
 *  - texel_quad_t  the 2x2 texel neighbourhood of a fragment
 *  - frac_t        horizontal and vertical sub-texel fraction
 */
package tmu_pix_pkg;

	// RGB565, red in the top bits
	typedef struct packed {
		logic [4:0] r; // 0..31
		logic [5:0] g; // 0..63, one extra bit of precision
		logic [4:0] b; // 0..31
	} rgb565_t;

	// Neighbourhood around the sample point
	//   a b
	//   c d
	typedef struct packed {
		rgb565_t a; // Top-left
		rgb565_t b; // Top-right
		rgb565_t c; // Bottom-left
		rgb565_t d; // Bottom-right
	} texel_quad_t;

	// Position of the sample inside the quad, in units of 1/64
	// Zero on both axes selects texel a alone
	typedef struct packed {
		logic [5:0] x_frac; // Weight towards b and d
		logic [5:0] y_frac; // Weight towards c and d
	} frac_t;

endpackage

//--- verif/tb_tmu_blend_array.sv
/*
 * Testbench for the bilinear blend array
 *  - LFSR stimulus for texels, fractions, addresses, gaps and stalls
 *  - reference blend model and in-order result scoreboard
 *  - reset state, corner fractions, latency, random and stalled runs
 */
`include "tmu_cfg.svh"

module tb_tmu_blend_array;

	localparam int N_RANDOM     = 300;                // Fragments per random run
	localparam int N_FRAGS      = 3 + 2 * N_RANDOM;   // Corner, latency and random runs
	localparam int STALL_MARGIN = 4 * N_RANDOM;       // Room for gaps and ack stalls
	localparam int CYC_LIMIT    = N_FRAGS * (`TMU_LANES + 5) + STALL_MARGIN + 20;

	logic                     sys_clk;
	logic                     sys_rst;
	logic                     pipe_stb_i;
	tmu_frag_pkg::frag_t      frag_i;
	logic                     pipe_ack_o;
	logic                     pipe_stb_o;
	tmu_frag_pkg::blend_res_t res_o;
	logic                     pipe_ack_i;
	logic                     busy_o;

	logic [31:0] lfsr = 32'h730c_4b4f;
	int cyc = 0;      // Rising edges seen so far
	int errors = 0;
	int checks = 0;
	int n_in = 0;     // Fragments accepted
	int n_out = 0;    // Results taken
	tmu_frag_pkg::blend_res_t exp_q[$]; // Expected results, oldest first

	tmu_blend_array UUT (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (pipe_stb_i),
		.frag_i     (frag_i),
		.pipe_ack_o (pipe_ack_o),
		.pipe_stb_o (pipe_stb_o),
		.res_o      (res_o),
		.pipe_ack_i (pipe_ack_i),
		.busy_o     (busy_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Bilinear rule, weights sum to 4096
	function automatic tmu_frag_pkg::blend_res_t blend_ref(input tmu_frag_pkg::frag_t f);
		int x;
		int y;
		int pa;
		int pb;
		int pc;
		int pd;
		int r;
		int g;
		int b;
		tmu_frag_pkg::blend_res_t res;
		x = int'(f.frac.x_frac);
		y = int'(f.frac.y_frac);
		pa = (64 - x) * (64 - y);
		pb = x * (64 - y);
		pc = (64 - x) * y;
		pd = x * y;
		r = pa * f.texels.a.r + pb * f.texels.b.r + pc * f.texels.c.r + pd * f.texels.d.r;
		g = pa * f.texels.a.g + pb * f.texels.b.g + pc * f.texels.c.g + pd * f.texels.d.g;
		b = pa * f.texels.a.b + pb * f.texels.b.b + pc * f.texels.c.b + pd * f.texels.d.b;
		res.dadr = f.dadr;    // Address untouched
		res.color.r = 5'(r >> 12);
		res.color.g = 6'(g >> 12);
		res.color.b = 5'(b >> 12);
		return res;
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED at time %0t: %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	task automatic random_frag(output tmu_frag_pkg::frag_t f);
		logic [31:0] r;
		take_bits(16, r);
		f.texels.a = r[15:0];
		take_bits(16, r);
		f.texels.b = r[15:0];
		take_bits(16, r);
		f.texels.c = r[15:0];
		take_bits(16, r);
		f.texels.d = r[15:0];
		take_bits(6, r);
		f.frac.x_frac = r[5:0];
		take_bits(6, r);
		f.frac.y_frac = r[5:0];
		take_bits(`TMU_FML_DEPTH - 1, r);
		f.dadr = r[`TMU_FML_DEPTH-2:0];
	endtask

	// One fragment through an idle array
	// Returns the result and the edges from acceptance to its output transfer
	task automatic single_frag(input tmu_frag_pkg::frag_t f, output tmu_frag_pkg::blend_res_t res,
			output int lat);
		int t0;
		frag_i <= f;
		pipe_stb_i <= 1'b1;
		pipe_ack_i <= 1'b1;
		@(negedge sys_clk);
		while (!pipe_ack_o) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
		end
		t0 = cyc + 1; // Edge of acceptance
		@(posedge sys_clk);
		pipe_stb_i <= 1'b0;
		@(negedge sys_clk);
		while (!pipe_stb_o)
			@(negedge sys_clk);
		lat = cyc + 1 - t0; // Result leaves on the next edge
		res = res_o;
		@(posedge sys_clk);
	endtask

	// Starts and ends on a rising edge
	task automatic run_random(input int count, input bit gaps, input bit stalls);
		logic [31:0] r;
		tmu_frag_pkg::frag_t f;
		int sent;
		bit offer;
		sent = 0;
		offer = 1'b0;
		while (sent < count) begin
			if (!offer) begin
				take_bits(2, r);
				if (!gaps || r[1:0] != 2'd0) begin // Gap one time in four
					random_frag(f);
					frag_i <= f;
					offer = 1'b1;
				end
			end
			pipe_stb_i <= offer; // Held until taken
			if (stalls) begin
				take_bits(2, r);
				pipe_ack_i <= (r[1:0] != 2'd0);
			end else begin
				pipe_ack_i <= 1'b1;
			end
			@(negedge sys_clk);
			if (offer && pipe_ack_o) begin
				sent++;
				offer = 1'b0;
			end
			@(posedge sys_clk);
		end
		pipe_stb_i <= 1'b0;
		pipe_ack_i <= 1'b1;
	endtask

	// Once every lane is empty nothing may be left outstanding
	task automatic drain_and_check();
		@(negedge sys_clk);
		while (busy_o) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
		end
		check_val("expected queue size", 64'd0, 64'(exp_q.size()));
		@(posedge sys_clk);
	endtask

	// Every accepted fragment gets its expected result
	always @(negedge sys_clk) begin
		if (!sys_rst && pipe_stb_i && pipe_ack_o) begin
			exp_q.push_back(blend_ref(frag_i));
			n_in++;
		end
	end

	always @(negedge sys_clk) begin : compare_results
		tmu_frag_pkg::blend_res_t exp_res;
		if (!sys_rst && pipe_stb_o && pipe_ack_i) begin
			n_out++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("Result at time %0t with no fragment outstanding", $time);
			end else begin
				exp_res = exp_q.pop_front(); // Arrival order
				check_val("res_o.dadr", 64'(exp_res.dadr), 64'(res_o.dadr));
				check_val("res_o.color", 64'(exp_res.color), 64'(res_o.color));
			end
		end
	end

	always @(posedge sys_clk)
		cyc <= cyc + 1;

	always @(posedge sys_clk) begin
		if (cyc >= CYC_LIMIT) begin
			$display("Timeout after %0d cycles, %0d results still outstanding", cyc,
				exp_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		tmu_frag_pkg::frag_t f;
		tmu_frag_pkg::blend_res_t res;
		tmu_frag_pkg::blend_res_t exp_res;
		int lat;
		sys_rst = 1'b1;
		pipe_stb_i = 1'b0;
		frag_i = '0;
		pipe_ack_i = 1'b1;
		repeat (10) @(posedge sys_clk);
		sys_rst <= 1'b0;

		// Idle state straight after reset
		@(negedge sys_clk);
		check_val("pipe_stb_o", 64'd0, 64'(pipe_stb_o));
		check_val("busy_o", 64'd0, 64'(busy_o));
		check_val("pipe_ack_o", 64'd1, 64'(pipe_ack_o));
		@(posedge sys_clk);

		random_frag(f);
		f.frac = '0; // Texel a alone
		single_frag(f, res, lat);
		check_val("res_o.color", 64'(f.texels.a), 64'(res.color));
		check_val("res_o.dadr", 64'(f.dadr), 64'(res.dadr));

		random_frag(f);
		f.frac.x_frac = 6'd0;
		f.frac.y_frac = 6'd63; // Mostly texel c
		single_frag(f, res, lat);
		exp_res = blend_ref(f);
		check_val("res_o.color", 64'(exp_res.color), 64'(res.color));
		check_val("res_o.dadr", 64'(f.dadr), 64'(res.dadr));

		random_frag(f);
		single_frag(f, res, lat);
		check_val("latency", 64'd5, 64'(lat));

		run_random(N_RANDOM, 1'b0, 1'b0); // Full rate
		drain_and_check();
		run_random(N_RANDOM, 1'b1, 1'b1); // Gaps and back-pressure
		drain_and_check();
		check_val("results out", 64'(n_in), 64'(n_out));

		$display("Fragments in %0d, results out %0d, checks %0d, errors %0d",
			n_in, n_out, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
